// File: src/pyrPkg.sv
`default_nettype none

package pyrPkg;

    ////////////////////
    // pixel format
    ////////////////////

    // grayscale depth shared by the RAMs, the bus and the averaging datapath
    localparam int PIX_W = 8;

    typedef logic [PIX_W-1:0] pixelT;

    ////////////////////
    // control FSM
    ////////////////////

    typedef enum logic [1:0] {
        IDLE,           // waiting for start
        SRC_SCAN,       // address generator walks the source level
        DRAIN_WRITE,    // last averaged pixel still in the pipe
        WAIT_ACK        // level finished, consumer may read it
    } pyrStateT;

endpackage

`default_nettype wire

// File: src/ramPortIf.sv
`timescale 1ns/1ps
`default_nettype none

// one port of a pixel RAM, sized for the full level-0 image
interface ramPortIf
    import pyrPkg::*;
#(
    parameter int IMG_SIDE = 8
) ();

    localparam int AW = 2 * $clog2(IMG_SIDE);

    logic          cs;
    logic          we;
    logic [AW-1:0] addr;
    pixelT         wrData;
    pixelT         rdData;    // valid one cycle after a read

    modport owner  (output cs, output we, output addr, output wrData, input rdData);
    modport memory (input cs, input we, input addr, input wrData, output rdData);

endinterface

`default_nettype wire

// File: src/pixelRam.sv
`timescale 1ns/1ps
`default_nettype none

module pixelRam
    import pyrPkg::*;
#(
    parameter int IMG_SIDE = 8
) (
    input  wire logic  clk,
    ramPortIf.memory   port
);

    localparam int DEPTH = IMG_SIDE * IMG_SIDE;

    pixelT mem [DEPTH];

    // single port, write has priority over read
    always_ff @(posedge clk) begin
        if (port.cs) begin
            if (port.we) begin
                mem[port.addr] <= port.wrData;
            end
            else begin
                port.rdData <= mem[port.addr];   // one cycle read latency
            end
        end
    end

endmodule

`default_nettype wire

// File: src/pyrCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module pyrCtrl
    import pyrPkg::*;
#(
    parameter int IMG_SIDE = 8
) (
    input  wire logic                             clk,
    input  wire logic                             rst_n,
    input  wire logic                             start,
    input  wire logic                             levelAck,
    input  wire logic                             lastRead,
    input  wire logic                             wrPending,
    output      logic                             busy,
    output      logic                             levelValid,
    output      logic [$clog2($clog2(IMG_SIDE)+1)-1:0] level,
    output      logic                             srcIsB,
    output      logic                             scanEn,
    output      logic [$clog2(IMG_SIDE):0]        levelSide
);

    localparam int LW  = $clog2(IMG_SIDE);    // number of levels above level 0
    localparam int LVW = $clog2(LW + 1);

    pyrStateT state, nextState;
    logic     lastLevel;

    assign lastLevel  = (level == LVW'(LW));   // 1x1 just finished
    assign scanEn     = (state == SRC_SCAN);
    assign busy       = (state == SRC_SCAN) || (state == DRAIN_WRITE);
    assign levelValid = (state == WAIT_ACK);

    ////////////////////
    // next state
    ////////////////////
    always_comb begin
        nextState = state;
        case (state)
            IDLE:        if (start) nextState = SRC_SCAN;
            SRC_SCAN:    if (lastRead) nextState = DRAIN_WRITE;
            DRAIN_WRITE: if (!wrPending) nextState = WAIT_ACK;
            WAIT_ACK:    if (levelAck) nextState = lastLevel ? IDLE : SRC_SCAN;
            default:     nextState = IDLE;
        endcase
    end

    ////////////////////
    // state, level counter and ping-pong select
    ////////////////////
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            level     <= '0;
            srcIsB    <= 1'b0;
            levelSide <= (LW+1)'(IMG_SIDE);
        end
        else begin
            state <= nextState;
            if (state == IDLE && start) begin
                level     <= LVW'(1);            // first level built from the loaded image
                srcIsB    <= 1'b0;
                levelSide <= (LW+1)'(IMG_SIDE);
            end
            else if (state == WAIT_ACK && levelAck) begin
                if (lastLevel) begin
                    level  <= '0;
                    srcIsB <= 1'b0;
                end
                else begin
                    level     <= level + 1'b1;
                    srcIsB    <= !srcIsB;        // finished level becomes next source
                    levelSide <= levelSide >> 1;
                end
            end
        end
    end

    // the consumer never reads a level while the engine still owns the RAMs
    assert property (@(posedge clk) disable iff (!rst_n) !(levelValid && busy));

    // a stray start mid-pyramid must not restart the scan from full size
    assert property (@(posedge clk) disable iff (!rst_n)
        (start && state != IDLE) |=> levelSide <= $past(levelSide));

endmodule

`default_nettype wire

// File: src/pyrAddrGen.sv
`timescale 1ns/1ps
`default_nettype none

module pyrAddrGen #(
    parameter int IMG_SIDE = 8
) (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire logic                            scanEn,
    input  wire logic [$clog2(IMG_SIDE):0]       levelSide,
    output      logic [2*$clog2(IMG_SIDE)-1:0]   rdAddr,
    output      logic                            rdValid,
    output      logic                            blockLast,
    output      logic                            lastRead,
    output      logic [2*$clog2(IMG_SIDE)-1:0]   dstIndex
);

    localparam int LW = $clog2(IMG_SIDE);
    localparam int AW = 2 * LW;

    logic [LW-1:0] bx, by;       // block column and row in the output level
    logic [1:0]    q;            // quadrant, bit 0 is column and bit 1 is row
    logic [LW-1:0] outSide;
    logic [LW:0]   srcRow, srcCol;

    assign outSide = levelSide[LW:1];
    assign srcRow  = {by, q[1]};
    assign srcCol  = {bx, q[0]};

    // one read per cycle for as long as the scan runs
    assign rdValid   = scanEn;
    assign rdAddr    = AW'(srcRow) * AW'(levelSide) + AW'(srcCol);
    assign dstIndex  = AW'(by) * AW'(outSide) + AW'(bx);
    assign blockLast = scanEn && (q == 2'd3);
    assign lastRead  = blockLast && (bx == outSide - 1'b1) && (by == outSide - 1'b1);

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            bx <= '0;
            by <= '0;
            q  <= '0;
        end
        else if (!scanEn) begin    // park at the first block between levels
            bx <= '0;
            by <= '0;
            q  <= '0;
        end
        else begin
            q <= q + 1'b1;
            if (q == 2'd3) begin
                if (bx == outSide - 1'b1) begin
                    bx <= '0;
                    by <= by + 1'b1;
                end
                else begin
                    bx <= bx + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/pyrDownscaler.sv
`timescale 1ns/1ps
`default_nettype none

module pyrDownscaler
    import pyrPkg::*;
#(
    parameter int ADDR_W = 6
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              rdValid,
    input  wire logic              blockLast,
    input  wire logic [ADDR_W-1:0] dstIndex,
    input  wire pixelT             srcData,     // source RAM output, seen from the owner side
    ramPortIf.owner                dst,
    output      logic              wrPending
);

    logic              vldD, lastD;   // strobes lined up with the returning data
    logic [ADDR_W-1:0] idxD;
    logic [1:0]        cnt;           // words taken in the current block
    logic [PIX_W+1:0]  acc, sum;
    logic              wrEn;
    logic [ADDR_W-1:0] wrAddr;
    pixelT             wrPix;

    assign sum = ((cnt == 2'd0) ? '0 : acc) + {2'b00, srcData};

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            vldD  <= 1'b0;
            lastD <= 1'b0;
            cnt   <= '0;
            wrEn  <= 1'b0;
        end
        else begin
            vldD  <= rdValid;
            lastD <= blockLast;
            wrEn  <= vldD && lastD;
            if (vldD) cnt <= lastD ? 2'd0 : cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        idxD <= dstIndex;
        if (vldD) acc <= sum;
        if (vldD && lastD) begin
            wrPix  <= sum[PIX_W+1:2];    // truncating mean of four
            wrAddr <= idxD;
        end
    end

    assign dst.cs     = wrEn;
    assign dst.we     = wrEn;
    assign dst.addr   = wrAddr;
    assign dst.wrData = wrPix;

    // data still on its way back or a write not yet issued
    assign wrPending = vldD || wrEn;

    // the address generator must close every block after its fourth read
    assert property (@(posedge clk) disable iff (!rst_n)
        (vldD && cnt == 2'd3) |-> lastD);

endmodule

`default_nettype wire

// File: src/pyrWbSlave.sv
`timescale 1ns/1ps
`default_nettype none

module pyrWbSlave
    import pyrPkg::*;
#(
    parameter int IMG_SIDE = 8
) (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire logic                           cyc,
    input  wire logic                           stb,
    input  wire logic                           we,
    input  wire logic [2*$clog2(IMG_SIDE):0]    adr,
    input  wire pixelT                          datWr,
    input  wire logic                           busy,
    output      pixelT                          datRd,
    output      logic                           ack,
    ramPortIf.owner                             portA,
    ramPortIf.owner                             portB
);

    localparam int AW = 2 * $clog2(IMG_SIDE);

    logic access;
    logic bankSel;    // bank of the access being acknowledged

    // one RAM access per bus cycle, none while the engine runs
    assign access = cyc && stb && !busy && !ack;

    assign portA.cs     = access && !adr[AW];
    assign portA.we     = we;
    assign portA.addr   = adr[AW-1:0];
    assign portA.wrData = datWr;

    assign portB.cs     = access && adr[AW];
    assign portB.we     = we;
    assign portB.addr   = adr[AW-1:0];
    assign portB.wrData = datWr;

    // read data arrives together with ack
    assign datRd = bankSel ? portB.rdData : portA.rdData;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            ack     <= 1'b0;
            bankSel <= 1'b0;
        end
        else begin
            ack <= access;
            if (access) bankSel <= adr[AW];
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) ack |-> (cyc && stb));

endmodule

`default_nettype wire

// File: src/pyrTop.sv
`timescale 1ns/1ps
`default_nettype none

module pyrTop
    import pyrPkg::*;
#(
    parameter int IMG_SIDE = 8
) (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic                              start,
    input  wire logic                              levelAck,
    input  wire logic                              cyc,
    input  wire logic                              stb,
    input  wire logic                              we,
    input  wire logic [2*$clog2(IMG_SIDE):0]       adr,     // top bit picks RAM B
    input  wire pixelT                             datWr,
    output      logic                              busy,
    output      logic                              levelValid,
    output      logic [$clog2($clog2(IMG_SIDE)+1)-1:0] level,
    output      pixelT                             datRd,
    output      logic                              ack
);

    localparam int LW = $clog2(IMG_SIDE);
    localparam int AW = 2 * LW;

    logic          srcIsB, scanEn, lastRead, wrPending;
    logic          rdValid, blockLast;
    logic [LW:0]   levelSide;
    logic [AW-1:0] rdAddr, dstIndex;
    pixelT         srcData;

    ramPortIf #(.IMG_SIDE(IMG_SIDE)) ramA ();
    ramPortIf #(.IMG_SIDE(IMG_SIDE)) ramB ();
    ramPortIf #(.IMG_SIDE(IMG_SIDE)) wbA ();
    ramPortIf #(.IMG_SIDE(IMG_SIDE)) wbB ();
    ramPortIf #(.IMG_SIDE(IMG_SIDE)) engDst ();

    ////////////////////
    // RAM port routing
    ////////////////////

    // engine owns both RAMs while busy, source reads and destination writes
    assign ramA.cs     = busy ? (srcIsB ? engDst.cs : rdValid) : wbA.cs;
    assign ramA.we     = busy ? (srcIsB && engDst.we) : wbA.we;
    assign ramA.addr   = busy ? (srcIsB ? engDst.addr : rdAddr) : wbA.addr;
    assign ramA.wrData = busy ? engDst.wrData : wbA.wrData;

    assign ramB.cs     = busy ? (srcIsB ? rdValid : engDst.cs) : wbB.cs;
    assign ramB.we     = busy ? (!srcIsB && engDst.we) : wbB.we;
    assign ramB.addr   = busy ? (srcIsB ? rdAddr : engDst.addr) : wbB.addr;
    assign ramB.wrData = busy ? engDst.wrData : wbB.wrData;

    assign wbA.rdData    = ramA.rdData;
    assign wbB.rdData    = ramB.rdData;
    assign srcData       = srcIsB ? ramB.rdData : ramA.rdData;
    assign engDst.rdData = srcIsB ? ramA.rdData : ramB.rdData;

    ////////////////////
    // blocks
    ////////////////////

    pyrCtrl #(.IMG_SIDE(IMG_SIDE)) ctrl0 (
        .clk(clk), .rst_n(rst_n), .start(start), .levelAck(levelAck),
        .lastRead(lastRead), .wrPending(wrPending), .busy(busy),
        .levelValid(levelValid), .level(level), .srcIsB(srcIsB),
        .scanEn(scanEn), .levelSide(levelSide)
    );

    pyrAddrGen #(.IMG_SIDE(IMG_SIDE)) addrGen0 (
        .clk(clk), .rst_n(rst_n), .scanEn(scanEn), .levelSide(levelSide),
        .rdAddr(rdAddr), .rdValid(rdValid), .blockLast(blockLast),
        .lastRead(lastRead), .dstIndex(dstIndex)
    );

    pyrDownscaler #(.ADDR_W(AW)) down0 (
        .clk(clk), .rst_n(rst_n), .rdValid(rdValid), .blockLast(blockLast),
        .dstIndex(dstIndex), .srcData(srcData), .dst(engDst.owner),
        .wrPending(wrPending)
    );

    pyrWbSlave #(.IMG_SIDE(IMG_SIDE)) wb0 (
        .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .datWr(datWr), .busy(busy), .datRd(datRd), .ack(ack),
        .portA(wbA.owner), .portB(wbB.owner)
    );

    pixelRam #(.IMG_SIDE(IMG_SIDE)) ramA0 (.clk(clk), .port(ramA.memory));
    pixelRam #(.IMG_SIDE(IMG_SIDE)) ramB0 (.clk(clk), .port(ramB.memory));

endmodule

`default_nettype wire

// File: bench/pyrTb.sv
`timescale 1ns/1ps
`default_nettype none

module pyrTb
    import pyrPkg::*;
;

    localparam int IMG_SIDE    = 8;
    localparam int LW          = $clog2(IMG_SIDE);
    localparam int AW          = 2 * LW;
    localparam int LVW         = $clog2(LW + 1);
    localparam int NPIX        = IMG_SIDE * IMG_SIDE;
    localparam int WB_TIMEOUT  = 2000;    // covers a full level while the bus is stalled
    localparam int LVL_TIMEOUT = 2000;

    typedef logic [AW:0]    adrT;
    typedef logic [LVW-1:0] levelT;

    logic  clk, rst_n, start, levelAck, cyc, stb, we, busy, levelValid, ack;
    adrT   adr;
    pixelT datWr, datRd;
    levelT level;

    logic [16:0] lfsr;
    pixelT       refLvl [0:LW][0:NPIX-1];    // level 0 holds the loaded image

    pyrTop #(.IMG_SIDE(IMG_SIDE)) dut0 (
        .clk(clk), .rst_n(rst_n), .start(start), .levelAck(levelAck),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datWr(datWr),
        .busy(busy), .levelValid(levelValid), .level(level), .datRd(datRd), .ack(ack)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////
    // stimulus and reference
    ////////////////////

    // x^17 + x^14 + 1, new bit enters at the bottom
    function automatic logic [16:0] lfsrStep(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    function pixelT randPixel();
        pixelT p;
        p = '0;
        for (int i = 0; i < PIX_W; i++) begin
            lfsr = lfsrStep(lfsr);
            p    = {p[PIX_W-2:0], lfsr[0]};
        end
        return p;
    endfunction

    // every level from the one below, mean of each 2x2 block rounded down
    function automatic void pyramidRef();
        int side, sum;
        for (int l = 1; l <= LW; l++) begin
            side = IMG_SIDE >> l;
            for (int r = 0; r < side; r++) begin
                for (int c = 0; c < side; c++) begin
                    sum = int'(refLvl[l-1][(2*r)*(2*side) + 2*c])
                        + int'(refLvl[l-1][(2*r)*(2*side) + 2*c + 1])
                        + int'(refLvl[l-1][(2*r+1)*(2*side) + 2*c])
                        + int'(refLvl[l-1][(2*r+1)*(2*side) + 2*c + 1]);
                    refLvl[l][r*side + c] = pixelT'(sum / 4);
                end
            end
        end
    endfunction

    ////////////////////
    // checks
    ////////////////////

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "run aborted");
    endtask

    task automatic checkPixel(input string name, input pixelT expected, input pixelT actual);
        if (actual !== expected)
            abortRun($sformatf("ERROR %s: expected %0d, actual %0d", name, expected, actual));
    endtask

    task automatic checkLevel(input string name, input levelT expected, input levelT actual);
        if (actual !== expected)
            abortRun($sformatf("ERROR %s: expected %0d, actual %0d", name, expected, actual));
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            abortRun($sformatf("ERROR %s: expected %0b, actual %0b", name, expected, actual));
    endtask

    ////////////////////
    // bus and handshake
    ////////////////////

    task automatic tick();
        @(posedge clk);
        #1;    // drive and sample clear of the edge
    endtask

    task automatic wbWrite(input adrT a, input pixelT d);
        int n;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = a;
        datWr = d;
        n     = 0;
        tick();
        while (!ack) begin
            if (n == WB_TIMEOUT) abortRun($sformatf("write to address %0h never acknowledged", a));
            tick();
            n++;
        end
        tick();    // request stays up through the edge that samples ack
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wbRead(input adrT a, output pixelT d);
        int n;
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = a;
        n   = 0;
        tick();
        while (!ack) begin
            if (n == WB_TIMEOUT) abortRun($sformatf("read from address %0h never acknowledged", a));
            tick();
            n++;
        end
        if (busy) abortRun("bus acknowledged a read while the engine was busy");
        d = datRd;
        tick();    // request stays up through the edge that samples ack
        cyc = 1'b0;
        stb = 1'b0;
    endtask

    task automatic waitLevelValid(input string name);
        int       n;
        pyrStateT st;
        n = 0;
        while (!levelValid) begin
            if (n == LVL_TIMEOUT) begin
                st = dut0.ctrl0.state;
                abortRun($sformatf("%s: levelValid never rose, FSM in %s", name, st.name()));
            end
            tick();
            n++;
        end
    endtask

    // kind 0 random, 1 all zero, 2 all full scale
    task automatic loadImage(input string name, input int kind);
        pixelT p;
        for (int i = 0; i < NPIX; i++) begin
            p = (kind == 0) ? randPixel() : ((kind == 1) ? 8'h00 : 8'hff);
            refLvl[0][i] = p;
            wbWrite({1'b0, AW'(i)}, p);
        end
        for (int i = 0; i < NPIX; i++) begin
            wbRead({1'b0, AW'(i)}, p);
            checkPixel($sformatf("%s readback %0d", name, i), refLvl[0][i], p);
        end
    endtask

    task automatic runPyramid(input string name, input logic probeBusy);
        pixelT d;
        int    side;
        pyramidRef();
        start = 1'b1;
        tick();
        start = 1'b0;
        checkFlag({name, " busy after start"}, 1'b1, busy);
        if (probeBusy) begin    // held off until level 1 is done
            wbRead({1'b0, AW'(5)}, d);
            checkPixel({name, " read held while busy"}, refLvl[0][5], d);
        end
        for (int l = 1; l <= LW; l++) begin
            waitLevelValid(name);
            checkLevel({name, " level number"}, levelT'(l), level);
            side = IMG_SIDE >> l;
            for (int i = 0; i < side * side; i++) begin
                wbRead({l[0], AW'(i)}, d);    // odd levels sit in RAM B
                checkPixel($sformatf("%s level %0d pixel %0d", name, l, i), refLvl[l][i], d);
            end
            levelAck = 1'b1;
            tick();
            levelAck = 1'b0;
        end
        for (int i = 0; i < 8; i++) begin    // engine stays idle after the 1x1 level
            tick();
            checkFlag({name, " busy after last ack"}, 1'b0, busy);
        end
        checkFlag({name, " levelValid after last ack"}, 1'b0, levelValid);
        checkLevel({name, " level after last ack"}, '0, level);
    endtask

    ////////////////////
    // test sequence
    ////////////////////

    initial begin
        rst_n    = 1'b0;
        start    = 1'b0;
        levelAck = 1'b0;
        cyc      = 1'b0;
        stb      = 1'b0;
        we       = 1'b0;
        adr      = '0;
        datWr    = '0;
        lfsr     = 17'd65691;
        repeat (16) tick();
        rst_n = 1'b1;
        tick();

        checkFlag("reset busy", 1'b0, busy);
        checkFlag("reset levelValid", 1'b0, levelValid);
        checkFlag("reset ack", 1'b0, ack);
        checkLevel("reset level", '0, level);

        loadImage("random image 1", 0);
        runPyramid("pyramid 1", 1'b1);
        loadImage("random image 2", 0);
        runPyramid("pyramid 2", 1'b0);
        loadImage("zero image", 1);
        runPyramid("zero pyramid", 1'b0);
        loadImage("full-scale image", 2);
        runPyramid("full-scale pyramid", 1'b0);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
src/pyrPkg.sv
src/ramPortIf.sv
src/pixelRam.sv
src/pyrCtrl.sv
src/pyrAddrGen.sv
src/pyrDownscaler.sv
src/pyrWbSlave.sv
src/pyrTop.sv
bench/pyrTb.sv

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and look for the pass line in the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module pyrTb -f tb.f -o pyrSim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/pyrSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF '*** PASSED ***' "$LOG"; then
    exit 0
else
    echo "pass line missing from $LOG"
    exit 1
fi
